// File: hw/cpuDma_settings.svh
// cpuDma settings: bus and FIFO widths, FIFO depth and the register map of the DMA master
`ifndef CPUDMA_SETTINGS_SVH
`define CPUDMA_SETTINGS_SVH

// bus word and FIFO entry
`define CPUDMA_DATA_W 32

// byte address on the memory bus
`define CPUDMA_ADDR_W 32

// FIFO sizing
`define CPUDMA_FIFO_DEPTH 8
`define CPUDMA_FIFO_LW 4 // holds 0..8

// register map, 1-bit register address
`define CPUDMA_REG_CTRL 1'b0
`define CPUDMA_REG_ADDR 1'b1

`endif

// File: hw/cpuDmaPkg.sv
// cpuDmaPkg: shared types of the SCSI DMA bus master, its FIFO and its registers
`include "cpuDma_settings.svh"

package cpuDmaPkg;

  typedef logic [`CPUDMA_DATA_W-1:0]  busData_t;   // bus / FIFO word
  typedef logic [`CPUDMA_ADDR_W-1:0]  busAddr_t;   // byte address
  typedef logic [`CPUDMA_FIFO_LW-1:0] fifoLevel_t; // occupancy 0..depth
  typedef logic [0:0]                 regAddr_t;   // register select

  // control register, bit 0 is ena
  typedef struct packed {
    logic flush; // write out a partial FIFO
    logic dir;   // 1 = FIFO to memory
    logic ena;   // transfers allowed
  } dmaCtrl_t;

  typedef struct packed {
    logic almostFull; // one free slot left
    logic full;
    logic empty;
  } fifoStat_t;

  typedef enum logic [2:0] {
    sIdle    = 3'd0,
    sReqBus  = 3'd1,
    sWrLoad  = 3'd2,
    sWrWait  = 3'd3,
    sRdWait  = 3'd4,
    sRelease = 3'd5
  } smState_t;

  // transition terms, one bit per arc of the master FSM
  typedef struct packed {
    logic startWr;
    logic startRd;
    logic granted;
    logic abort;
    logic wrAck;
    logic wrMore;
    logic rdAck;
    logic rdMore;
    logic released;
  } cpuTerms_t;

endpackage

// File: hw/cpuDmaRegs.sv
// cpuDmaRegs: control register and transfer address register of the DMA master
`timescale 1ns/1ps
`include "cpuDma_settings.svh"

module cpuDmaRegs (
  input  logic                 CLK90,
  input  logic                 RST_,
  input  logic                 regWr,
  input  cpuDmaPkg::regAddr_t  regAddr,
  input  cpuDmaPkg::busData_t  regWdata,
  input  logic                 addrInc,
  output cpuDmaPkg::dmaCtrl_t  ctrl,
  output cpuDmaPkg::busAddr_t  xferAddr
);

  logic wrCtrl;
  logic wrAddr;

  assign wrCtrl = regWr && (regAddr == `CPUDMA_REG_CTRL);
  assign wrAddr = regWr && (regAddr == `CPUDMA_REG_ADDR);

  // control fields from the low bits of the write data
  always_ff @(posedge CLK90 or negedge RST_) begin
    if (!RST_) begin
      ctrl <= '0; // disabled, memory to FIFO
    end else if (wrCtrl) begin
      ctrl <= cpuDmaPkg::dmaCtrl_t'(regWdata[2:0]);
    end
  end

  // transfer address, post-incremented per acknowledged word
  always_ff @(posedge CLK90 or negedge RST_) begin
    if (!RST_) begin
      xferAddr <= '0;
    end else if (wrAddr) begin
      xferAddr <= {regWdata[`CPUDMA_ADDR_W-1:2], 2'b00}; // force word alignment
    end else if (addrInc) begin
      xferAddr <= xferAddr + cpuDmaPkg::busAddr_t'(4); // next 32-bit word
    end
  end

endmodule

// File: hw/dmaFifo.sv
// dmaFifo: word FIFO between the SCSI side and the bus master, first-word fall-through
`timescale 1ns/1ps
`include "cpuDma_settings.svh"

module dmaFifo (
  input  logic                   CLK90,
  input  logic                   RST_,
  input  logic                   scsiPush,
  input  cpuDmaPkg::busData_t    scsiWdata,
  input  logic                   smPush,
  input  cpuDmaPkg::busData_t    smWdata,
  input  logic                   scsiPop,
  input  logic                   smPop,
  output cpuDmaPkg::busData_t    fifoRdata,
  output cpuDmaPkg::fifoStat_t   fifoStat,
  output cpuDmaPkg::fifoLevel_t  level
);

  localparam int PtrW = $clog2(`CPUDMA_FIFO_DEPTH);

  cpuDmaPkg::busData_t   mem [`CPUDMA_FIFO_DEPTH];
  logic [PtrW-1:0]       wrPtr;
  logic [PtrW-1:0]       rdPtr;
  cpuDmaPkg::fifoLevel_t count;
  cpuDmaPkg::busData_t   pushData;
  logic                  doPush;
  logic                  doPop;

  // only one side pushes at a time, master wins if both
  assign pushData = smPush ? smWdata : scsiWdata;
  assign doPush   = (scsiPush || smPush) && !fifoStat.full;  // drop push when full
  assign doPop    = (scsiPop || smPop) && !fifoStat.empty;   // drop pop when empty

  always_ff @(posedge CLK90) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge CLK90 or negedge RST_) begin
    if (!RST_) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + PtrW'(1); // wraps at depth
      if (doPop)  rdPtr <= rdPtr + PtrW'(1);
      case ({doPush, doPop})
        2'b10:   count <= count + cpuDmaPkg::fifoLevel_t'(1);
        2'b01:   count <= count - cpuDmaPkg::fifoLevel_t'(1);
        default: count <= count; // none, or push and pop together
      endcase
    end
  end

  assign fifoRdata           = mem[rdPtr]; // head word
  assign fifoStat.empty      = (count == '0);
  assign fifoStat.full       = (count == cpuDmaPkg::fifoLevel_t'(`CPUDMA_FIFO_DEPTH));
  assign fifoStat.almostFull = (count == cpuDmaPkg::fifoLevel_t'(`CPUDMA_FIFO_DEPTH - 1));
  assign level               = count;

endmodule

// File: hw/cpuSmTerms.sv
// cpuSmTerms: registers dsack and decodes state and inputs into the master's transition terms
`timescale 1ns/1ps

module cpuSmTerms (
  input  logic                  CLK90,
  input  logic                  RST_,
  input  cpuDmaPkg::smState_t   state,
  input  cpuDmaPkg::dmaCtrl_t   ctrl,
  input  cpuDmaPkg::fifoStat_t  fifoStat,
  input  logic                  busGrant,
  input  logic                  dsack,
  output cpuDmaPkg::cpuTerms_t  terms
);

  logic dsackS;
  logic inIdle;
  logic inReqBus;
  logic inWrWait;
  logic inRdWait;
  logic inRelease;
  logic wrReady;

  // acknowledge seen one cycle late
  always_ff @(posedge CLK90 or negedge RST_) begin
    if (!RST_) begin
      dsackS <= 1'b0;
    end else begin
      dsackS <= dsack;
    end
  end

  // state matches
  assign inIdle    = (state == cpuDmaPkg::sIdle);
  assign inReqBus  = (state == cpuDmaPkg::sReqBus);
  assign inWrWait  = (state == cpuDmaPkg::sWrWait);
  assign inRdWait  = (state == cpuDmaPkg::sRdWait);
  assign inRelease = (state == cpuDmaPkg::sRelease);

  // full FIFO, or a flush of whatever is left
  assign wrReady = fifoStat.full || (ctrl.flush && !fifoStat.empty);

  always_comb begin
    terms          = '0;
    // burst starts
    terms.startWr  = inIdle && ctrl.ena && ctrl.dir && wrReady;
    terms.startRd  = inIdle && ctrl.ena && !ctrl.dir && fifoStat.empty;

    // arbitration
    terms.granted  = inReqBus && busGrant;
    terms.abort    = inReqBus && !ctrl.ena; // ena dropped before grant

    // write words
    terms.wrAck    = inWrWait && dsackS;
    terms.wrMore   = inWrWait && dsackS && !fifoStat.empty;

    // read words, almostFull means this push fills it
    terms.rdAck    = inRdWait && dsackS;
    terms.rdMore   = inRdWait && dsackS && !fifoStat.almostFull;

    terms.released = inRelease;
  end

endmodule

// File: hw/cpuSm.sv
// cpuSm: bus master FSM, drives the memory bus controls and the FIFO strobes
`timescale 1ns/1ps

module cpuSm (
  input  logic                  CLK90,
  input  logic                  RST_,
  input  cpuDmaPkg::cpuTerms_t  terms,
  input  cpuDmaPkg::dmaCtrl_t   ctrl,
  input  cpuDmaPkg::busAddr_t   xferAddr,
  input  cpuDmaPkg::busData_t   fifoRdata,
  input  cpuDmaPkg::busData_t   rdata,
  output cpuDmaPkg::smState_t   state,
  output logic                  busReq,
  output logic                  as,
  output logic                  rw,
  output cpuDmaPkg::busAddr_t   addr,
  output cpuDmaPkg::busData_t   wdata,
  output logic                  smPush,
  output cpuDmaPkg::busData_t   smWdata,
  output logic                  smPop,
  output logic                  addrInc,
  output logic                  xferDone
);

  cpuDmaPkg::smState_t nextState;
  logic                dirR;       // 1 = write burst in progress
  cpuDmaPkg::busData_t wdataR;

  // next state, first matching term wins
  always_comb begin
    nextState = state;
    priority case (1'b1)
      terms.startWr,
      terms.startRd:  nextState = cpuDmaPkg::sReqBus;
      terms.abort:    nextState = cpuDmaPkg::sIdle;    // no bus cycle
      terms.granted:  nextState = dirR ? cpuDmaPkg::sWrLoad : cpuDmaPkg::sRdWait;
      terms.wrMore:   nextState = cpuDmaPkg::sWrLoad;
      terms.wrAck:    nextState = cpuDmaPkg::sRelease; // FIFO drained
      terms.rdMore:   nextState = cpuDmaPkg::sReqBus;  // as gap before next read
      terms.rdAck:    nextState = cpuDmaPkg::sRelease; // FIFO now full
      terms.released: nextState = cpuDmaPkg::sIdle;
      default: begin
        if (state == cpuDmaPkg::sWrLoad) begin
          nextState = cpuDmaPkg::sWrWait; // load always takes one cycle
        end
      end
    endcase
  end

  always_ff @(posedge CLK90 or negedge RST_) begin
    if (!RST_) begin
      state <= cpuDmaPkg::sIdle;
      dirR  <= 1'b0;
    end else begin
      state <= nextState;
      // latch direction only when a burst starts
      if (terms.startWr || terms.startRd) begin
        dirR <= ctrl.dir;
      end
    end
  end

  // write word taken from the FIFO head
  always_ff @(posedge CLK90) begin
    if (state == cpuDmaPkg::sWrLoad) begin
      wdataR <= fifoRdata;
    end
  end

  // bus controls from registered state
  assign busReq = (state == cpuDmaPkg::sReqBus) || (state == cpuDmaPkg::sWrLoad) ||
                  (state == cpuDmaPkg::sWrWait) || (state == cpuDmaPkg::sRdWait);
  assign as     = (state == cpuDmaPkg::sWrWait) || (state == cpuDmaPkg::sRdWait);
  assign rw     = busReq && !dirR; // fixed for the whole burst
  assign addr   = xferAddr;        // advances only after as drops
  assign wdata  = wdataR;

  // FIFO side
  assign smPop   = (state == cpuDmaPkg::sWrLoad);
  assign smPush  = terms.rdAck;    // dsack still held here
  assign smWdata = rdata;

  assign addrInc  = terms.wrAck || terms.rdAck; // one per word
  assign xferDone = (state == cpuDmaPkg::sRelease);

endmodule

// File: hw/cpuDmaTop.sv
// cpuDmaTop: SCSI DMA bus master with registers, word FIFO and the 68030-style bus FSM
`timescale 1ns/1ps

module cpuDmaTop (
  input  logic                 CLK90,
  input  logic                 RST_,
  // register port
  input  logic                 regWr,
  input  cpuDmaPkg::regAddr_t  regAddr,
  input  cpuDmaPkg::busData_t  regWdata,
  // SCSI side of the FIFO
  input  logic                 scsiPush,
  input  cpuDmaPkg::busData_t  scsiWdata,
  input  logic                 scsiPop,
  output cpuDmaPkg::busData_t  fifoRdata,
  output logic                 fifoEmpty,
  output logic                 fifoFull,
  // memory bus
  input  logic                 busGrant,
  input  logic                 dsack,
  input  cpuDmaPkg::busData_t  rdata,
  output logic                 busReq,
  output logic                 as,
  output logic                 rw,
  output cpuDmaPkg::busAddr_t  addr,
  output cpuDmaPkg::busData_t  wdata,
  output logic                 xferDone
);

  cpuDmaPkg::dmaCtrl_t  ctrl;
  cpuDmaPkg::busAddr_t  xferAddr;
  cpuDmaPkg::fifoStat_t fifoStat;
  cpuDmaPkg::smState_t  state;
  cpuDmaPkg::cpuTerms_t terms;
  cpuDmaPkg::busData_t  smWdata;
  logic                 smPush;
  logic                 smPop;
  logic                 addrInc;

  assign fifoEmpty = fifoStat.empty;
  assign fifoFull  = fifoStat.full;

  cpuDmaRegs i_regs (
    .CLK90, .RST_, .regWr, .regAddr, .regWdata, .addrInc, .ctrl, .xferAddr
  );

  // level is not needed by the master
  dmaFifo i_fifo (
    .CLK90, .RST_, .scsiPush, .scsiWdata, .smPush, .smWdata, .scsiPop, .smPop,
    .fifoRdata, .fifoStat, .level()
  );

  cpuSmTerms i_terms (
    .CLK90, .RST_, .state, .ctrl, .fifoStat, .busGrant, .dsack, .terms
  );

  cpuSm i_sm (
    .CLK90, .RST_, .terms, .ctrl, .xferAddr, .fifoRdata, .rdata, .state,
    .busReq, .as, .rw, .addr, .wdata, .smPush, .smWdata, .smPop, .addrInc, .xferDone
  );

endmodule

// File: dv/cpuDma_sva.sv
// cpuDmaSva: bus protocol and FIFO port assertions bound to the DMA master top level
`timescale 1ns/1ps

module cpuDmaSva (
  input logic                 CLK90,
  input logic                 RST_,
  input logic                 busReq,
  input logic                 busGrant,
  input logic                 as,
  input logic                 smPush,
  input logic                 scsiPush,
  input cpuDmaPkg::busAddr_t  addr,
  input cpuDmaPkg::busData_t  wdata
);

  // address strobe only inside an owned bus tenure
  asOwned: assert property (@(posedge CLK90) disable iff (!RST_)
    as |-> (busReq && busGrant))
    else $error("as high without busReq and busGrant");

  // one writer into the FIFO per cycle
  onePusher: assert property (@(posedge CLK90) disable iff (!RST_)
    !(smPush && scsiPush))
    else $error("smPush and scsiPush together");

  // bus cycle signals hold for the whole strobe
  addrStable: assert property (@(posedge CLK90) disable iff (!RST_)
    (as && $past(as)) |-> ($stable(addr) && $stable(wdata)))
    else $error("addr or wdata changed while as high");

endmodule

bind cpuDmaTop cpuDmaSva i_sva (
  .CLK90(CLK90), .RST_(RST_), .busReq(busReq), .busGrant(busGrant), .as(as),
  .smPush(smPush), .scsiPush(scsiPush), .addr(addr), .wdata(wdata)
);

// File: dv/cpuDmaTb.sv
// testbench cpuDmaTb drives the DMA bus master from a row table against a bus memory model
`timescale 1ns/1ps
`include "cpuDma_settings.svh"

module cpuDmaTb;

  logic CLK90;
  logic RST_;
  logic regWr;
  cpuDmaPkg::regAddr_t regAddr;
  cpuDmaPkg::busData_t regWdata;
  logic scsiPush;
  cpuDmaPkg::busData_t scsiWdata;
  logic scsiPop;
  cpuDmaPkg::busData_t fifoRdata;
  logic fifoEmpty;
  logic fifoFull;
  logic busGrant;
  logic dsack;
  cpuDmaPkg::busData_t rdata;
  logic busReq;
  logic as;
  logic rw;
  cpuDmaPkg::busAddr_t addr;
  cpuDmaPkg::busData_t wdata;
  logic xferDone;

  // row table of direction (1 = to memory), start address, words, flush and grant withheld
  localparam int NumRows = 5;
  logic        rowDir   [NumRows] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
  logic [31:0] rowAddr  [NumRows] = '{32'h00, 32'h40, 32'h80, 32'h20, 32'hC0};
  int          rowCnt   [NumRows] = '{8, 3, 16, 0, 8};
  logic        rowFlush [NumRows] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
  logic        rowHold  [NumRows] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

  logic [31:0] mem  [64]; // bus memory, word indexed
  logic [31:0] snap [64];
  logic holdGrant;
  logic expRw;
  int   doneCnt;
  int   asCnt;
  int   gDly;
  int   aDly;

  cpuDmaTop i_dut (.*);

  initial begin
    CLK90 = 1'b0;
    forever #20 CLK90 = ~CLK90;
  end

  function automatic logic [31:0] pattern(int r, int w);
    return {8'hD0, 8'(r), 16'(w)};
  endfunction

  task automatic check(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH t=%0t %s exp=%h act=%h", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic regWrite(logic a, logic [31:0] d);
    @(negedge CLK90);
    regWr = 1'b1;
    regAddr = a;
    regWdata = d;
    @(negedge CLK90);
    regWr = 1'b0;
  endtask

  task automatic pushWord(logic [31:0] d);
    @(negedge CLK90);
    scsiPush = 1'b1;
    scsiWdata = d;
    @(negedge CLK90);
    scsiPush = 1'b0;
  endtask

  task automatic popCheck(logic [31:0] exp);
    @(negedge CLK90);
    check("fifoRdata", exp, fifoRdata); // head shown before the pop
    scsiPop = 1'b1;
    @(negedge CLK90);
    scsiPop = 1'b0;
  endtask

  // grant model
  always @(negedge CLK90) begin
    if (!busReq) begin
      busGrant = 1'b0;
      gDly = -1;
    end else if (!busGrant && !holdGrant) begin
      if (gDly < 0) gDly = int'($urandom_range(0, 3));
      if (gDly == 0) busGrant = 1'b1;
      else gDly--;
    end
  end

  // slave model drops dsack on the falling edge after as falls
  always @(negedge CLK90) begin
    if (!as) begin
      dsack = 1'b0;
      aDly = -1;
    end else if (!dsack) begin
      if (aDly < 0) aDly = int'($urandom_range(0, 3));
      if (aDly == 0) begin
        dsack = 1'b1;
        if (rw) rdata = mem[addr[7:2]];
        else mem[addr[7:2]] = wdata;
      end else begin
        aDly--;
      end
    end
  end

  // bus monitor
  always @(negedge CLK90) begin
    if (RST_ && xferDone) doneCnt++;
    if (RST_ && as) begin
      asCnt++;
      check("rw", 32'(expRw), 32'(rw));
    end
  end

  // watchdog sized from the table
  initial begin
    int cycles;
    cycles = 200;
    for (int r = 0; r < NumRows; r++) cycles += rowCnt[r] * 12;
    #(cycles * 40);
    $display("timeout: the DUT hung waiting for a bus or FIFO event");
    $display("ERRORS FOUND");
    $fatal(1);
  end

  initial begin
    logic [5:0] idx;
    void'($urandom(5));
    RST_ = 1'b0;
    regWr = 1'b0;
    regAddr = '0;
    regWdata = '0;
    scsiPush = 1'b0;
    scsiWdata = '0;
    scsiPop = 1'b0;
    busGrant = 1'b0;
    dsack = 1'b0;
    rdata = '0;
    holdGrant = 1'b0;
    expRw = 1'b0;
    doneCnt = 0;
    asCnt = 0;
    gDly = -1;
    aDly = -1;
    for (int i = 0; i < 64; i++) mem[i] = 32'h5A000000 ^ (32'(i) * 32'h9E3779B1);
    // idle outputs through reset and before the first register write
    for (int c = 0; c < 14; c++) begin
      @(negedge CLK90);
      if (c == 9) RST_ = 1'b1;
      if (c > 0) begin
        check("busReq", 0, 32'(busReq));
        check("as", 0, 32'(as));
        check("xferDone", 0, 32'(xferDone));
        check("fifoEmpty", 1, 32'(fifoEmpty));
        check("fifoFull", 0, 32'(fifoFull));
      end
    end
    for (int r = 0; r < NumRows; r++) begin
      holdGrant = rowHold[r];
      expRw = !rowDir[r];
      doneCnt = 0;
      asCnt = 0;
      for (int i = 0; i < 64; i++) snap[i] = mem[i];
      for (int i = 0; i < rowCnt[r]; i++) begin
        idx = rowAddr[r][7:2] + 6'(i);
        if (!rowDir[r]) mem[idx] = pattern(r, i); // prefetch source
      end
      regWrite(`CPUDMA_REG_ADDR, rowAddr[r]);
      if (rowDir[r]) begin
        regWrite(`CPUDMA_REG_CTRL, 32'h3); // ena, dir
        for (int i = 0; i < rowCnt[r]; i++) pushWord(pattern(r, i));
        if (rowFlush[r]) regWrite(`CPUDMA_REG_CTRL, 32'h7);
        while (doneCnt == 0) @(negedge CLK90);
        repeat (3) @(negedge CLK90);
        check("xferDone pulses", 1, 32'(doneCnt));
        check("busReq", 0, 32'(busReq));
        check("fifoEmpty", 1, 32'(fifoEmpty));
        check("fifoFull", 0, 32'(fifoFull));
        for (int i = 0; i < rowCnt[r]; i++) begin
          idx = rowAddr[r][7:2] + 6'(i);
          check("mem", pattern(r, i), mem[idx]);
        end
      end else if (rowHold[r]) begin
        regWrite(`CPUDMA_REG_CTRL, 32'h1);
        while (!busReq) @(negedge CLK90);
        repeat (6) @(negedge CLK90);
        regWrite(`CPUDMA_REG_CTRL, 32'h0); // abort before grant
        repeat (2) @(negedge CLK90);
        check("busReq", 0, 32'(busReq));
        check("as cycles", 0, 32'(asCnt));
        for (int i = 0; i < 64; i++) check("mem", snap[i], mem[i]);
      end else begin
        regWrite(`CPUDMA_REG_CTRL, 32'h1);
        for (int c = 0; c < rowCnt[r] / 8; c++) begin
          while (!(fifoFull && !busReq)) @(negedge CLK90);
          if (c == rowCnt[r] / 8 - 1) regWrite(`CPUDMA_REG_CTRL, 32'h0); // no more refill
          for (int i = 0; i < 8; i++) popCheck(pattern(r, c * 8 + i));
        end
        repeat (3) @(negedge CLK90);
        check("xferDone pulses", 32'(rowCnt[r] / 8), 32'(doneCnt));
        check("busReq", 0, 32'(busReq));
        check("fifoEmpty", 1, 32'(fifoEmpty));
        check("fifoFull", 0, 32'(fifoFull));
      end
      regWrite(`CPUDMA_REG_CTRL, 32'h0);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: flist.f
+incdir+hw
hw/cpuDmaPkg.sv
hw/cpuDmaRegs.sv
hw/dmaFifo.sv
hw/cpuSmTerms.sv
hw/cpuSm.sv
hw/cpuDmaTop.sv
dv/cpuDma_sva.sv
dv/cpuDmaTb.sv

// File: Makefile
TOP = cpuDmaTb

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build lint clean
